// File: source/sieve_pkg.sv
`default_nettype none

package sieve_pkg;

  //////////////////////////////
  // widths

  typedef logic [15:0]  num_t;      // candidate, prime or latency count
  typedef logic [26:0]  mem_addr_t; // byte address on the app port
  typedef logic [127:0] mem_data_t; // one data beat
  typedef logic [15:0]  bcd_t;      // four bcd digits

  // number n sits at byte address n << SLOT_SHIFT
  localparam int SLOT_SHIFT = 8;

  //////////////////////////////
  // memory app port

  typedef enum logic [2:0] {
    cmd_write = 3'd0,
    cmd_read  = 3'd1
  } mem_cmd_e;

  typedef struct packed {
    logic      en;
    mem_cmd_e  cmd;
    mem_addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic      wren;
    logic      last;  // end of burst, always one beat here
    mem_data_t data;
  } mem_wdata_t;

  typedef struct packed {
    logic      rdy;       // command accepted when en is also high
    logic      wdf_rdy;   // write beat accepted when wren is also high
    logic      rd_valid;
    mem_data_t rd_data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/sieve_engine.sv
`timescale 1ns/1ns
`default_nettype none

module sieve_engine #(
  parameter int NUM_MAX = 10000
) (
  input  wire                      ui_clk,
  input  wire                      rst_in,
  input  wire sieve_pkg::mem_rsp_t mem_rsp,
  output sieve_pkg::mem_req_t      sieve_req,
  output sieve_pkg::mem_wdata_t    sieve_wdata,
  output logic                     sieve_done
);
  import sieve_pkg::*;

  typedef enum logic [3:0] {
    st_boot,
    st_prep,
    st_fill_data,  // beat carrying n
    st_fill_cmd,   // write command for slot n
    st_rd_cmd,     // read candidate p
    st_rd_wait,
    st_mark_data,  // zero beat
    st_mark_cmd,   // write command for a multiple of p
    st_done
  } state_e;

  state_e state;
  num_t   num_wr;      // slot being written
  num_t   num_rd;      // current candidate p
  num_t   first_mult;  // 2p
  num_t   next_mult;   // next multiple after num_wr

  assign first_mult = num_rd << 1;
  assign next_mult  = num_wr + num_rd;

  //////////////////////////////
  // fill and mark sequence

  always_ff @(posedge ui_clk) begin
    if (rst_in) begin
      state <= st_boot;
    end else begin
      case (state)
        st_boot: state <= st_prep;
        st_prep: begin
          state  <= st_fill_data;
          num_wr <= num_t'(2);
        end
        st_fill_data: begin
          if (mem_rsp.wdf_rdy) begin
            state <= st_fill_cmd;
          end
        end
        st_fill_cmd: begin
          if (mem_rsp.rdy) begin
            if (num_wr < NUM_MAX) begin
              state  <= st_fill_data;
              num_wr <= num_wr + num_t'(1);
            end else begin
              state  <= st_rd_cmd;  // table full, start marking
              num_rd <= num_t'(2);
            end
          end
        end
        st_rd_cmd: begin
          if (mem_rsp.rdy) begin
            state <= st_rd_wait;
          end
        end
        st_rd_wait: begin
          if (mem_rsp.rd_valid) begin
            if (mem_rsp.rd_data != '0 && first_mult <= NUM_MAX) begin
              state  <= st_mark_data;  // p survived, strike its multiples
              num_wr <= first_mult;
            end else if (num_rd < NUM_MAX) begin
              state  <= st_rd_cmd;
              num_rd <= num_rd + num_t'(1);
            end else begin
              state <= st_done;
            end
          end
        end
        st_mark_data: begin
          if (mem_rsp.wdf_rdy) begin
            state <= st_mark_cmd;
          end
        end
        st_mark_cmd: begin
          if (mem_rsp.rdy) begin
            if (next_mult <= NUM_MAX) begin
              state  <= st_mark_data;
              num_wr <= next_mult;
            end else if (num_rd < NUM_MAX) begin
              state  <= st_rd_cmd;
              num_rd <= num_rd + num_t'(1);
            end else begin
              state <= st_done;
            end
          end
        end
        st_done: state <= st_done;  // parked until reset
        default: state <= st_boot;
      endcase
    end
  end

  //////////////////////////////
  // port drive, decoded from state

  always_comb begin
    sieve_req   = '{en: 1'b0, cmd: cmd_write, addr: '0};
    sieve_wdata = '{wren: 1'b0, last: 1'b0, data: '0};
    case (state)
      st_fill_data: begin
        sieve_wdata.wren = 1'b1;
        sieve_wdata.last = 1'b1;
        sieve_wdata.data = mem_data_t'(num_wr);
      end
      st_mark_data: begin
        sieve_wdata.wren = 1'b1;
        sieve_wdata.last = 1'b1;  // data stays zero
      end
      st_fill_cmd, st_mark_cmd: begin
        sieve_req.en   = 1'b1;
        sieve_req.addr = mem_addr_t'(num_wr) << SLOT_SHIFT;
      end
      st_rd_cmd: begin
        sieve_req.en   = 1'b1;
        sieve_req.cmd  = cmd_read;
        sieve_req.addr = mem_addr_t'(num_rd) << SLOT_SHIFT;
      end
      default: ;
    endcase
  end

  assign sieve_done = (state == st_done);

endmodule

`default_nettype wire

// File: source/prime_walker.sv
`timescale 1ns/1ns
`default_nettype none

module prime_walker #(
  parameter int NUM_MAX     = 10000,
  parameter int STEP_CYCLES = 2**24
) (
  input  wire                        ui_clk,
  input  wire                        rst_in,
  input  wire                        sieve_done,
  input  wire sieve_pkg::mem_req_t   sieve_req,
  input  wire sieve_pkg::mem_wdata_t sieve_wdata,
  input  wire sieve_pkg::mem_rsp_t   mem_rsp,
  input  wire                        hold,
  input  wire                        restart,
  output sieve_pkg::mem_req_t        mem_req,
  output sieve_pkg::mem_wdata_t      mem_wdata,
  output sieve_pkg::num_t            prime,
  output sieve_pkg::num_t            latency
);
  import sieve_pkg::*;

  localparam int TICK_W = $clog2(STEP_CYCLES + 1);
  localparam mem_wdata_t IDLE_BEAT = '{wren: 1'b0, last: 1'b0, data: '0};

  typedef enum logic [1:0] {
    wk_idle,
    wk_read,
    wk_wait
  } walk_e;

  walk_e             state;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  num_t              pos;       // last number looked at
  num_t              pos_next;
  num_t              lat_cnt;
  mem_req_t          walk_req;

  // free-running step timer from reset
  assign tick = (tick_cnt == TICK_W'(STEP_CYCLES - 1));

  always_ff @(posedge ui_clk) begin
    if (rst_in || tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  assign pos_next = (pos >= NUM_MAX) ? num_t'(2) : pos + num_t'(1);  // wrap to 2

  //////////////////////////////
  // walk fsm

  always_ff @(posedge ui_clk) begin
    if (rst_in) begin
      state   <= wk_idle;
      pos     <= num_t'(1);  // first step lands on 2
      prime   <= '0;
      latency <= '0;
    end else begin
      case (state)
        wk_idle: begin
          if (sieve_done && tick && !hold) begin
            state   <= wk_read;
            pos     <= pos_next;
            lat_cnt <= '0;
          end else if (restart) begin
            pos <= num_t'(2);
          end
        end
        wk_read: begin
          lat_cnt <= lat_cnt + num_t'(1);
          if (mem_rsp.rdy) begin
            state <= wk_wait;
          end
        end
        wk_wait: begin
          lat_cnt <= lat_cnt + num_t'(1);
          if (mem_rsp.rd_valid) begin
            if (mem_rsp.rd_data == '0) begin
              state <= wk_read;  // composite, keep searching
              pos   <= pos_next;
            end else begin
              state   <= wk_idle;
              prime   <= pos;
              latency <= lat_cnt + num_t'(1);  // includes the rd_valid cycle
            end
          end
        end
        default: state <= wk_idle;
      endcase
    end
  end

  //////////////////////////////
  // port handover

  assign walk_req = '{
    en:   (state == wk_read),
    cmd:  cmd_read,
    addr: mem_addr_t'(pos) << SLOT_SHIFT
  };

  assign mem_req   = sieve_done ? walk_req : sieve_req;
  assign mem_wdata = sieve_done ? IDLE_BEAT : sieve_wdata;  // walker never writes

endmodule

`default_nettype wire

// File: source/bcd_converter.sv
`timescale 1ns/1ns
`default_nettype none

module bcd_converter #(
  parameter int W = 16
) (
  input  wire  [W-1:0]         bin,
  output logic [W+(W-4)/3:0]   bcd
);

  localparam int BCD_W  = W + (W - 4) / 3 + 1;
  localparam int DIGITS = (BCD_W + 3) / 4;

  logic [4*DIGITS-1:0] acc;  // digit accumulator, msb first shift

  // shift-and-add-3, one input bit per pass
  always_comb begin
    acc = '0;
    for (int i = W - 1; i >= 0; i--) begin
      for (int d = 0; d < DIGITS; d++) begin
        if (acc[4*d +: 4] > 4'd4) begin
          acc[4*d +: 4] = acc[4*d +: 4] + 4'd3;
        end
      end
      acc = {acc[4*DIGITS-2:0], bin[i]};
    end
  end

  assign bcd = acc[BCD_W-1:0];

endmodule

`default_nettype wire

// File: source/segment_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module segment_scanner #(
  parameter int SCAN_CYCLES = 100000
) (
  input  wire                  ui_clk,
  input  wire                  rst_in,
  input  wire sieve_pkg::bcd_t upper,  // digits 7..4
  input  wire sieve_pkg::bcd_t lower,  // digits 3..0
  output logic [6:0]           cat,
  output logic [7:0]           an
);

  localparam int DWELL_W = $clog2(SCAN_CYCLES + 1);

  logic [7:0]         digit_sel;  // one-hot, bit 0 = rightmost digit
  logic [DWELL_W-1:0] dwell_cnt;
  logic [31:0]        digits;
  logic [3:0]         nibble;
  logic [6:0]         seg;        // active high, bit 0 = a ... bit 6 = g

  assign digits = {upper, lower};

  always_ff @(posedge ui_clk) begin
    if (rst_in) begin
      digit_sel <= 8'b0000_0001;
      dwell_cnt <= '0;
    end else if (dwell_cnt == DWELL_W'(SCAN_CYCLES)) begin
      dwell_cnt <= '0;
      digit_sel <= {digit_sel[6:0], digit_sel[7]};
    end else begin
      dwell_cnt <= dwell_cnt + 1'b1;
    end
  end

  // pick the nibble under the active anode
  always_comb begin
    nibble = '0;
    for (int i = 0; i < 8; i++) begin
      if (digit_sel[i]) begin
        nibble = nibble | digits[4*i +: 4];
      end
    end
  end

  //////////////////////////////
  // hex segment table

  always_comb begin
    case (nibble)
      4'h0: seg = 7'h3f;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5b;
      4'h3: seg = 7'h4f;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6d;
      4'h6: seg = 7'h7d;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7f;
      4'h9: seg = 7'h6f;
      4'ha: seg = 7'h77;
      4'hb: seg = 7'h7c;
      4'hc: seg = 7'h39;
      4'hd: seg = 7'h5e;
      4'he: seg = 7'h79;
      default: seg = 7'h71;  // f
    endcase
  end

  assign cat = ~seg;        // board drives low to light
  assign an  = ~digit_sel;

endmodule

`default_nettype wire

// File: source/prime_lookup_top.sv
`timescale 1ns/1ns
`default_nettype none

module prime_lookup_top #(
  parameter int NUM_MAX     = 10000,
  parameter int STEP_CYCLES = 2**24,
  parameter int SCAN_CYCLES = 100000
) (
  input  wire                      ui_clk,
  input  wire                      rst_in,
  input  wire                      hold,
  input  wire                      restart,
  input  wire sieve_pkg::mem_rsp_t mem_rsp,
  output sieve_pkg::mem_req_t      mem_req,
  output sieve_pkg::mem_wdata_t    mem_wdata,
  output sieve_pkg::num_t          prime,
  output sieve_pkg::num_t          latency,
  output logic                     sieve_done,
  output logic [6:0]               cat,
  output logic [7:0]               an
);
  import sieve_pkg::*;

  localparam int NUM_W  = $bits(num_t);
  localparam int BCD_FW = NUM_W + (NUM_W - 4) / 3 + 1;  // full converter width

  mem_req_t          sieve_req;
  mem_wdata_t        sieve_wdata;
  logic [BCD_FW-1:0] prime_bcd_full;
  logic [BCD_FW-1:0] latency_bcd_full;
  bcd_t              prime_bcd;
  bcd_t              latency_bcd;

  //////////////////////////////
  // memory side

  sieve_engine #(.NUM_MAX(NUM_MAX)) sieve (
    .ui_clk      (ui_clk),
    .rst_in      (rst_in),
    .mem_rsp     (mem_rsp),
    .sieve_req   (sieve_req),
    .sieve_wdata (sieve_wdata),
    .sieve_done  (sieve_done)
  );

  prime_walker #(.NUM_MAX(NUM_MAX), .STEP_CYCLES(STEP_CYCLES)) walker (
    .ui_clk      (ui_clk),
    .rst_in      (rst_in),
    .sieve_done  (sieve_done),
    .sieve_req   (sieve_req),
    .sieve_wdata (sieve_wdata),
    .mem_rsp     (mem_rsp),
    .hold        (hold),
    .restart     (restart),
    .mem_req     (mem_req),
    .mem_wdata   (mem_wdata),
    .prime       (prime),
    .latency     (latency)
  );

  //////////////////////////////
  // display side

  bcd_converter #(.W(NUM_W)) prime_conv (.bin(prime), .bcd(prime_bcd_full));
  bcd_converter #(.W(NUM_W)) latency_conv (.bin(latency), .bcd(latency_bcd_full));

  assign prime_bcd   = prime_bcd_full[15:0];    // four digits shown
  assign latency_bcd = latency_bcd_full[15:0];

  segment_scanner #(.SCAN_CYCLES(SCAN_CYCLES)) scanner (
    .ui_clk (ui_clk),
    .rst_in (rst_in),
    .upper  (latency_bcd),
    .lower  (prime_bcd),
    .cat    (cat),
    .an     (an)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // free running, 50% duty
  end

endmodule

`default_nettype wire

// File: verification/tb_memory_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory_model #(
  parameter int SEED  = 32'h3c21,
  parameter int DEPTH = 64
) (
  input  wire                        ui_clk,
  input  wire                        rst_in,
  input  wire sieve_pkg::mem_req_t   mem_req,
  input  wire sieve_pkg::mem_wdata_t mem_wdata,
  output sieve_pkg::mem_rsp_t        mem_rsp
);
  import sieve_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  mem_data_t        mem [DEPTH];  // one beat per slot
  mem_data_t        beat;         // last accepted write beat
  logic [IDX_W-1:0] rd_idx;
  int               rd_delay;     // cycles to the answer, 0 when idle

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {4{32'hc0de_0000 ^ i}};  // nonzero junk before the fill
    end
    beat     = '0;
    rd_idx   = '0;
    rd_delay = 0;
    mem_rsp  = '0;
    forever begin
      @(posedge ui_clk);
      if (rst_in) begin
        rd_delay = 0;
        mem_rsp <= '0;
      end else begin
        mem_rsp.rd_valid <= 1'b0;
        if (mem_wdata.wren && mem_rsp.wdf_rdy) begin
          beat = mem_wdata.data;
        end
        if (mem_req.en && mem_rsp.rdy) begin
          if (mem_req.cmd == cmd_write) begin
            mem[mem_req.addr[SLOT_SHIFT +: IDX_W]] = beat;
          end else begin
            rd_idx   = mem_req.addr[SLOT_SHIFT +: IDX_W];
            rd_delay = 1 + int'($urandom % 4);
          end
        end
        // read answer after 1 to 4 cycles
        if (rd_delay > 0) begin
          rd_delay--;
          if (rd_delay == 0) begin
            mem_rsp.rd_valid <= 1'b1;
            mem_rsp.rd_data  <= mem[rd_idx];
          end
        end
        mem_rsp.rdy     <= ($urandom % 4) != 0;  // about one stall in four
        mem_rsp.wdf_rdy <= ($urandom % 4) != 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_prime_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tb_prime_lookup;
  import sieve_pkg::*;

  localparam int NUM_MAX      = 60;
  localparam int STEP_CYCLES  = 64;
  localparam int SCAN_CYCLES  = 3;
  localparam int RESET_CYCLES = 8;
  localparam int OP_CYCLES    = 16;  // per port operation with stalls and read delay
  localparam int WALK_STEPS   = 40;

  logic       ui_clk;
  logic       rst_in;
  logic       hold;
  logic       restart;
  mem_req_t   mem_req;
  mem_wdata_t mem_wdata;
  mem_rsp_t   mem_rsp;
  num_t       prime;
  num_t       latency;
  logic       sieve_done;
  logic [6:0] cat;
  logic [7:0] an;

  int         errors = 0;
  mem_req_t   prev_req;
  mem_wdata_t prev_wdata;
  mem_rsp_t   prev_rsp;
  logic       prev_valid;
  logic       beat_pending;
  logic       read_pending;
  logic       write_offered;
  logic       done_seen;
  num_t       shown_prime;
  int         last_pos;      // last number the walk showed
  int         sel;
  int         shown_value;
  logic [3:0] digit;

  tb_clock_gen #(.PERIOD_NS(40)) clock (.clk(ui_clk));

  tb_memory_model #(.SEED(32'h3c21), .DEPTH(64)) mem_model (
    .ui_clk    (ui_clk),
    .rst_in    (rst_in),
    .mem_req   (mem_req),
    .mem_wdata (mem_wdata),
    .mem_rsp   (mem_rsp)
  );

  prime_lookup_top #(
    .NUM_MAX     (NUM_MAX),
    .STEP_CYCLES (STEP_CYCLES),
    .SCAN_CYCLES (SCAN_CYCLES)
  ) UUT (
    .ui_clk     (ui_clk),
    .rst_in     (rst_in),
    .hold       (hold),
    .restart    (restart),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .mem_wdata  (mem_wdata),
    .prime      (prime),
    .latency    (latency),
    .sieve_done (sieve_done),
    .cat        (cat),
    .an         (an)
  );

  //////////////////////////////
  // reference model

  function automatic bit trial_prime(int n);
    if (n < 2) return 1'b0;
    for (int d = 2; d * d <= n; d++) begin
      if (n % d == 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic int next_prime(int from);
    int n;
    n = from;
    do begin
      n = (n >= NUM_MAX) ? 2 : n + 1;  // wrap after the top
    end while (!trial_prime(n));
    return n;
  endfunction

  function automatic int prime_count();
    int count;
    count = 0;
    for (int n = 2; n <= NUM_MAX; n++) begin
      if (trial_prime(n)) count++;
    end
    return count;
  endfunction

  // fill writes and candidate reads plus the strike writes
  function automatic int sieve_ops();
    int ops;
    ops = 3 * (NUM_MAX - 1);
    for (int p = 2; 2 * p <= NUM_MAX; p++) begin
      if (trial_prime(p)) ops += 2 * (NUM_MAX / p - 1);
    end
    return ops;
  endfunction

  function automatic logic [3:0] decimal_digit(int value, int pos);
    int v;
    v = value;
    for (int i = 0; i < pos; i++) v = v / 10;
    return 4'(v % 10);
  endfunction

  function automatic logic [6:0] seg_pattern(logic [3:0] d);  // gfedcba with lit = 1
    case (d)
      4'd0: return 7'h3f;
      4'd1: return 7'h06;
      4'd2: return 7'h5b;
      4'd3: return 7'h4f;
      4'd4: return 7'h66;
      4'd5: return 7'h6d;
      4'd6: return 7'h7d;
      4'd7: return 7'h07;
      4'd8: return 7'h7f;
      4'd9: return 7'h6f;
      default: return 7'h00;
    endcase
  endfunction

  //////////////////////////////
  // port checks

  always @(posedge ui_clk) begin
    if (rst_in) begin
      prev_valid    = 1'b0;
      beat_pending  = 1'b0;
      read_pending  = 1'b0;
      write_offered = 1'b0;
      done_seen     = 1'b0;
    end else begin
      if (mem_wdata.wren) write_offered = 1'b1;
      if (!write_offered) begin
        assert (!mem_req.en && !sieve_done) else begin
          errors++;
          $display("** Error: mem_req.en = 0x%h, sieve_done = 0x%h before first write",
                   mem_req.en, sieve_done);
        end
        assert (prime == '0 && latency == '0) else begin
          errors++;
          $display("** Error: prime = 0x%h, latency = 0x%h, expected 0x0", prime, latency);
        end
      end
      if (mem_wdata.wren) begin
        assert (mem_wdata.last) else begin
          errors++;
          $display("** Error: mem_wdata.last = 0x%h on a write beat, expected 0x1",
                   mem_wdata.last);
        end
      end
      // back-pressure holds the request
      if (prev_valid && prev_req.en && !prev_rsp.rdy) begin
        assert (mem_req == prev_req) else begin
          errors++;
          $display("** Error: mem_req = 0x%h, expected held 0x%h", mem_req, prev_req);
        end
      end
      if (prev_valid && prev_wdata.wren && !prev_rsp.wdf_rdy) begin
        assert (mem_wdata == prev_wdata) else begin
          errors++;
          $display("** Error: mem_wdata = 0x%h, expected held 0x%h", mem_wdata, prev_wdata);
        end
      end
      if (mem_rsp.rd_valid) read_pending = 1'b0;
      if (mem_req.en && mem_rsp.rdy) begin
        if (mem_req.cmd == cmd_write) begin
          assert (beat_pending) else begin
            errors++;
            $display("write command to 0x%h accepted before its data beat", mem_req.addr);
          end
          assert (mem_req.addr[SLOT_SHIFT-1:0] == '0 && (mem_req.addr >> SLOT_SHIFT) >= 2 &&
                  (mem_req.addr >> SLOT_SHIFT) <= NUM_MAX) else begin
            errors++;
            $display("** Error: mem_req.addr = 0x%h, not a slot of 2 to %0d",
                     mem_req.addr, NUM_MAX);
          end
          beat_pending = 1'b0;
        end else begin
          assert (!read_pending) else begin
            errors++;
            $display("second read issued while one is still outstanding");
          end
          read_pending = 1'b1;
        end
      end
      if (mem_wdata.wren && mem_rsp.wdf_rdy) beat_pending = 1'b1;
      if (done_seen) begin
        assert (sieve_done && !mem_wdata.wren) else begin
          errors++;
          $display("** Error: sieve_done = 0x%h, mem_wdata.wren = 0x%h after the sieve",
                   sieve_done, mem_wdata.wren);
        end
      end
      if (sieve_done) done_seen = 1'b1;
      prev_req   = mem_req;
      prev_wdata = mem_wdata;
      prev_rsp   = mem_rsp;
      prev_valid = 1'b1;
    end
  end

  //////////////////////////////
  // walk and display checks

  always @(posedge ui_clk) begin
    if (rst_in) begin
      shown_prime = '0;
      last_pos    = 1;
    end else begin
      if (prime !== shown_prime) begin
        assert (prime == num_t'(next_prime(last_pos))) else begin
          errors++;
          $display("** Error: prime = 0x%h, expected 0x%h", prime,
                   num_t'(next_prime(last_pos)));
        end
        assert (latency != '0) else begin
          errors++;
          $display("** Error: latency = 0x%h at a prime update", latency);
        end
        shown_prime = prime;
        last_pos    = int'(prime);
      end
      if (restart) last_pos = 2;  // pulsed only while the walker idles
    end
  end

  always @(posedge ui_clk) begin
    if (!rst_in) begin
      assert ($countones(an) == 7) else begin
        errors++;
        $display("** Error: an = 0x%h, expected exactly one low bit", an);
      end
      sel = 0;
      for (int i = 0; i < 8; i++) begin
        if (!an[i]) sel = i;
      end
      shown_value = (sel < 4) ? int'(prime) : int'(latency);
      digit       = decimal_digit(shown_value, sel % 4);
      assert (cat == ~seg_pattern(digit)) else begin
        errors++;
        $display("** Error: cat = 0x%h, expected 0x%h on digit %0d", cat,
                 ~seg_pattern(digit), sel);
      end
    end
  end

  //////////////////////////////
  // stimulus

  task automatic wait_prime_change();
    num_t start;
    start = prime;
    do @(posedge ui_clk); while (prime == start);
  endtask

  task automatic check_table();
    mem_data_t expected;
    for (int n = 2; n <= NUM_MAX; n++) begin
      expected = trial_prime(n) ? mem_data_t'(n) : '0;
      assert (mem_model.mem[n] == expected) else begin
        errors++;
        $display("** Error: slot %0d = 0x%h, expected 0x%h", n, mem_model.mem[n], expected);
      end
    end
  endtask

  task automatic finish_run();
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  initial begin
    num_t held;
    rst_in  = 1'b1;
    hold    = 1'b0;
    restart = 1'b0;
    repeat (RESET_CYCLES) @(posedge ui_clk);
    rst_in <= 1'b0;
    while (sieve_done !== 1'b1) @(posedge ui_clk);
    check_table();
    repeat (prime_count() + 3) wait_prime_change();  // one lap then on through 2 and 3 to 5
    hold <= 1'b1;
    repeat (2 * STEP_CYCLES) @(posedge ui_clk);  // a search already started may still land
    held = prime;
    repeat (4 * STEP_CYCLES) begin
      @(posedge ui_clk);
      assert (prime == held) else begin
        errors++;
        $display("** Error: prime = 0x%h while held at 0x%h", prime, held);
      end
    end
    restart <= 1'b1;
    @(posedge ui_clk);
    restart <= 1'b0;
    hold    <= 1'b0;
    wait_prime_change();
    assert (prime == num_t'(3)) else begin
      errors++;
      $display("** Error: prime = 0x%h after restart, expected 0x3", prime);
    end
    wait_prime_change();
    finish_run();
  end

  // watchdog
  initial begin
    int limit;
    limit = RESET_CYCLES + OP_CYCLES * sieve_ops() + WALK_STEPS * STEP_CYCLES;
    repeat (limit) @(posedge ui_clk);
    $display("timeout after %0d cycles, the run did not complete (%0d errors)", limit, errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/sieve_pkg.sv
source/sieve_engine.sv
source/prime_walker.sv
source/bcd_converter.sv
source/segment_scanner.sv
source/prime_lookup_top.sv
verification/tb_clock_gen.sv
verification/tb_memory_model.sv
verification/tb_prime_lookup.sv
